//--- filelist.f
aesRoundPkg.sv
roundBus.sv
roundSequencer.sv
byteMixer.sv
addRoundKey.sv
tbSramModel.sv
tb_addRoundKey.sv

//--- run.sh
#!/bin/sh
# Builds the AddRoundKey testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module tb_addRoundKey -o simAddRoundKey

output=$(./obj_dir/simAddRoundKey)
echo "$output"

# The run passes only if the testbench printed its pass line
echo "$output" | grep -qx "ALL TESTS PASSED"

//--- tb_addRoundKey.sv
/*
 * AddRoundKey testbench
 * Runs the block against a behavioral SRAM and checks reset values,
 * fetch order, round timing and every written state word
 */
`timescale 1ns/1ns
`default_nettype none

module tb_addRoundKey;
	import aesRoundPkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam addrT KEY_BASE = 16'h0040;
	localparam addrT STATE_BASE = 16'h1234;
	localparam logic [15:0] LFSR_SEED = 16'd41553;
	localparam int CHAIN_ROUNDS = 20;
	localparam int NUM_ROUNDS = CHAIN_ROUNDS + 3;
	localparam int ROUND_LIMIT = 40;  // Cycles one round may take
	localparam int TIMEOUT_CYCLES = ROUND_LIMIT * NUM_ROUNDS + 4 * RESET_CYCLES;
	localparam int ONE_PULSE = 0;
	localparam int HOLD_HIGH = 1;
	localparam int MID_PULSES = 2;

	logic clk, n_rst, roundEnable, roundFinished, sramRead, sramWrite, loadEnable;
	addrT sramAddr, loadAddr;
	blockT sramWriteData, sramReadData, loadData;
	logic [15:0] lfsr;
	int errorCount, checkCount, roundsRun;
	blockT keyWord, stateWord, chain;

	addRoundKey #(.KEY_ADDR(KEY_BASE), .STATE_ADDR(STATE_BASE)) u_addRoundKey (
		.clk(clk), .n_rst(n_rst), .roundEnable(roundEnable), .roundFinished(roundFinished),
		.sramRead(sramRead), .sramWrite(sramWrite), .sramAddr(sramAddr),
		.sramWriteData(sramWriteData), .sramReadData(sramReadData));

	tbSramModel u_tbSramModel (
		.clk(clk), .sramRead(sramRead), .sramWrite(sramWrite), .sramAddr(sramAddr),
		.sramWriteData(sramWriteData), .sramReadData(sramReadData),
		.loadEnable(loadEnable), .loadAddr(loadAddr), .loadData(loadData));

	// **************************************************
	// Clock, watchdog and helpers
	// **************************************************

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: run still busy after %0d cycles, %0d errors so far", TIMEOUT_CYCLES,
			errorCount);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// Fibonacci LFSR for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic randomBlock(output blockT value);
		for (int i = 0; i < BLOCK_BYTES * 8; i++)
		begin
			lfsr = lfsrNext(lfsr);
			value[i] = lfsr[0];
		end
	endtask

	task automatic checkValue(input string name, input blockT expected, input blockT actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkIdleOutputs(input string name);
		checkValue({name, " roundFinished"}, '0, blockT'(roundFinished));
		checkValue({name, " sramRead"}, '0, blockT'(sramRead));
		checkValue({name, " sramWrite"}, '0, blockT'(sramWrite));
		checkValue({name, " sramAddr"}, '0, blockT'(sramAddr));
		checkValue({name, " sramWriteData"}, '0, sramWriteData);
	endtask

	task automatic loadWord(input addrT addr, input blockT data);
		loadEnable = 1'b1;
		loadAddr = addr;
		loadData = data;
		@(negedge clk);
		loadEnable = 1'b0;
	endtask

	// Starts one round at a falling edge, then samples every falling edge until a few
	// cycles past roundFinished. Cycle n is the one after the nth edge counted from E
	task automatic runRound(input string name, input int mode, input blockT expected);
		int cycle, finishCycle, finishCount, writeCycle, readBase, writeBase;
		cycle = 0;
		finishCycle = 0;
		finishCount = 0;
		writeCycle = 0;
		readBase = u_tbSramModel.readLog.size();
		writeBase = u_tbSramModel.writeAddrLog.size();
		roundsRun++;
		roundEnable = 1'b1;
		while (cycle < ROUND_LIMIT && (finishCycle == 0 || cycle < finishCycle + 4))
		begin
			@(negedge clk);
			cycle++;
			if (roundFinished)
			begin
				finishCount++;
				if (finishCycle == 0)
					finishCycle = cycle;
			end
			if (sramWrite && writeCycle == 0)
				writeCycle = cycle;
			if (mode == HOLD_HIGH)
				roundEnable = (finishCycle == 0) || (cycle == finishCycle);  // Also high in FINISH
			else
				roundEnable = (mode == MID_PULSES) && (cycle == 10 || cycle == 22);
		end
		roundEnable = 1'b0;
		if (finishCycle == 0)
		begin
			errorCount++;
			$display("%s: roundFinished never went high within %0d cycles", name, ROUND_LIMIT);
		end
		checkValue({name, " finish cycle"}, blockT'(25), blockT'(finishCycle));
		checkValue({name, " finish pulses"}, blockT'(1), blockT'(finishCount));
		checkValue({name, " write cycle"}, blockT'(24), blockT'(writeCycle));
		checkValue({name, " writes"}, blockT'(1),
			blockT'(u_tbSramModel.writeAddrLog.size() - writeBase));
		checkValue({name, " reads"}, blockT'(2), blockT'(u_tbSramModel.readLog.size() - readBase));
		if (u_tbSramModel.readLog.size() >= readBase + 2)
		begin
			checkValue({name, " first read"}, blockT'(KEY_BASE),
				blockT'(u_tbSramModel.readLog[readBase]));
			checkValue({name, " second read"}, blockT'(STATE_BASE),
				blockT'(u_tbSramModel.readLog[readBase + 1]));
		end
		if (u_tbSramModel.writeAddrLog.size() > writeBase)
		begin
			checkValue({name, " write addr"}, blockT'(STATE_BASE),
				blockT'(u_tbSramModel.writeAddrLog[writeBase]));
			checkValue({name, " write data"}, expected, u_tbSramModel.writeDataLog[writeBase]);
			checkValue({name, " reads before write"}, blockT'(readBase + 2),
				blockT'(u_tbSramModel.writeReadMark[writeBase]));
		end
	endtask

	// **************************************************
	// Test sequence
	// **************************************************

	initial
	begin
		n_rst = 1'b0;
		roundEnable = 1'b0;
		loadEnable = 1'b0;
		loadAddr = '0;
		loadData = '0;
		lfsr = LFSR_SEED;
		errorCount = 0;
		checkCount = 0;
		roundsRun = 0;
		repeat (RESET_CYCLES)
		begin
			@(negedge clk);
			checkIdleOutputs("during reset");
		end
		n_rst = 1'b1;
		repeat (2)
		begin
			@(negedge clk);
			checkIdleOutputs("after reset");
		end

		randomBlock(keyWord);
		randomBlock(stateWord);
		loadWord(KEY_BASE, keyWord);
		loadWord(STATE_BASE, stateWord);
		chain = keyWord ^ stateWord;
		runRound("single round", ONE_PULSE, chain);

		// Only the key is reloaded, the state is whatever the last round wrote
		for (int i = 0; i < CHAIN_ROUNDS; i++)
		begin
			randomBlock(keyWord);
			loadWord(KEY_BASE, keyWord);
			chain = chain ^ keyWord;
			runRound($sformatf("chain round %0d", i), ONE_PULSE, chain);
		end

		randomBlock(keyWord);
		randomBlock(stateWord);
		loadWord(KEY_BASE, keyWord);
		loadWord(STATE_BASE, stateWord);
		chain = keyWord ^ stateWord;
		runRound("enable held", HOLD_HIGH, chain);
		randomBlock(keyWord);
		loadWord(KEY_BASE, keyWord);
		chain = chain ^ keyWord;
		runRound("enable pulsed", MID_PULSES, chain);

		checkValue("key reads", blockT'(roundsRun), blockT'(u_tbSramModel.readsAt(KEY_BASE)));
		checkValue("state reads", blockT'(roundsRun), blockT'(u_tbSramModel.readsAt(STATE_BASE)));
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tbSramModel.sv
/*
 * SRAM model for the AddRoundKey testbench
 * Word table that answers a read one cycle after the strobe and logs
 * every read and write
 */
`timescale 1ns/1ns
`default_nettype none

module tbSramModel (
	input logic clk,
	input logic sramRead,
	input logic sramWrite,
	input aesRoundPkg::addrT sramAddr,
	input aesRoundPkg::blockT sramWriteData,
	output aesRoundPkg::blockT sramReadData,
	input logic loadEnable,  // Preloads a word from the testbench side
	input aesRoundPkg::addrT loadAddr,
	input aesRoundPkg::blockT loadData
);
	import aesRoundPkg::*;

	blockT mem [addrT];  // Only words that were stored exist
	int readCount [addrT];

	addrT readLog [$];
	addrT writeAddrLog [$];
	blockT writeDataLog [$];
	int writeReadMark [$];  // Number of reads logged when each write landed

	function automatic int readsAt(input addrT addr);
		if (readCount.exists(addr))
			return readCount[addr];
		return 0;
	endfunction

	initial
		sramReadData = '0;

	always @(posedge clk)
	begin
		if (sramRead)
		begin
			sramReadData <= mem.exists(sramAddr) ? mem[sramAddr] : '0;  // Held until the next read
			readLog.push_back(sramAddr);
			readCount[sramAddr] = readsAt(sramAddr) + 1;
		end
		if (sramWrite)
		begin
			mem[sramAddr] = sramWriteData;
			writeAddrLog.push_back(sramAddr);
			writeDataLog.push_back(sramWriteData);
			writeReadMark.push_back(readLog.size());
		end
		if (loadEnable)
			mem[loadAddr] = loadData;
	end

endmodule

`default_nettype wire

//--- addRoundKey.sv
/*
 * AddRoundKey
 * Top level of the AES AddRoundKey step. Joins the SRAM sequencer and the
 * byte mixer through the round bus and exposes the SRAM port
 */
`timescale 1ns/1ns
`default_nettype none

module addRoundKey #(
	parameter aesRoundPkg::addrT KEY_ADDR = 16,
	parameter aesRoundPkg::addrT STATE_ADDR = 32
) (
	input logic clk,
	input logic n_rst,

	// Round control
	input logic roundEnable,   // Sampled only while idle
	output logic roundFinished,

	// SRAM port
	output logic sramRead,
	output logic sramWrite,
	output aesRoundPkg::addrT sramAddr,
	output aesRoundPkg::blockT sramWriteData,
	input aesRoundPkg::blockT sramReadData  // Valid the cycle after sramRead
);

	// **************************************************
	// Sequencer to mixer link
	// **************************************************

	roundBus u_roundBus ();

	// **************************************************
	// SRAM sequencer
	// **************************************************

	roundSequencer #(
		.KEY_ADDR(KEY_ADDR),
		.STATE_ADDR(STATE_ADDR)
	) u_roundSequencer (
		.clk(clk),
		.n_rst(n_rst),
		.roundEnable(roundEnable),
		.roundFinished(roundFinished),
		.sramRead(sramRead),
		.sramWrite(sramWrite),
		.sramAddr(sramAddr),
		.sramWriteData(sramWriteData),
		.sramReadData(sramReadData),
		.bus(u_roundBus.seq)
	);

	// **************************************************
	// Byte lane mixer
	// **************************************************

	// Takes 16 cycles from the cycle after mixStart
	byteMixer u_byteMixer (
		.clk(clk),
		.n_rst(n_rst),
		.bus(u_roundBus.mix)
	);

endmodule

`default_nettype wire

//--- byteMixer.sv
/*
 * Byte mixer
 * Walks the byte lanes from lowest to highest, one per cycle, and stores
 * key XOR state for each lane in the new state register
 */
`timescale 1ns/1ns
`default_nettype none

module byteMixer (
	input logic clk,
	input logic n_rst,
	roundBus.mix bus
);
	import aesRoundPkg::*;

	logic busy;
	laneT lane;
	logic lastLane;

	byteT keyByte;
	byteT stateByte;
	byteT mixedByte;

	blockT newStateReg;

	// **************************************************
	// Lane counter
	// **************************************************

	assign lastLane = (lane == laneT'(BLOCK_BYTES - 1));

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			busy <= 1'b0;
			lane <= '0;
		end
		else if (bus.mixStart)
		begin
			busy <= 1'b1;
			lane <= '0;
		end
		else if (busy)
		begin
			lane <= lane + laneT'(1);  // Wraps back to lane 0 after the last one
			if (lastLane)
				busy <= 1'b0;
		end
	end

	assign bus.mixDone = busy && lastLane;

	// **************************************************
	// Lane datapath
	// **************************************************

	// Bit offset of a lane is its index times eight
	assign keyByte = bus.roundKey[{lane, 3'b000} +: 8];
	assign stateByte = bus.oldState[{lane, 3'b000} +: 8];

	// AddRoundKey is a plain XOR of key and state
	assign mixedByte = keyByte ^ stateByte;

	always_ff @(posedge clk)
	begin
		if (busy)
			newStateReg[{lane, 3'b000} +: 8] <= mixedByte;
	end

	// Lanes not yet written still hold the previous round's bytes
	assign bus.newState = newStateReg;

endmodule

`default_nettype wire

//--- roundSequencer.sv
/*
 * Round sequencer
 * Fetches the round key and the cipher state from SRAM, hands them to the
 * byte mixer, writes the mixed state back and pulses roundFinished
 */
`timescale 1ns/1ns
`default_nettype none

module roundSequencer #(
	parameter aesRoundPkg::addrT KEY_ADDR = 16,
	parameter aesRoundPkg::addrT STATE_ADDR = 32
) (
	input logic clk,
	input logic n_rst,
	input logic roundEnable,
	output logic roundFinished,
	output logic sramRead,
	output logic sramWrite,
	output aesRoundPkg::addrT sramAddr,
	output aesRoundPkg::blockT sramWriteData,
	input aesRoundPkg::blockT sramReadData,
	roundBus.seq bus
);
	import aesRoundPkg::*;

	// The parameters share their names with two states, so those two
	// states are always written with the package scope below

	seqStateT state;
	seqStateT nextState;

	blockT keyWord;    // Round key as read from KEY_ADDR
	blockT stateWord;  // Cipher state as read from STATE_ADDR

	// **************************************************
	// State register and next state
	// **************************************************

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
			state <= IDLE;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			IDLE:
			begin
				if (roundEnable)
					nextState = aesRoundPkg::KEY_ADDR;
			end
			aesRoundPkg::KEY_ADDR:
				nextState = KEY_READ;
			KEY_READ:
				nextState = KEY_CAPTURE;
			KEY_CAPTURE:
				nextState = aesRoundPkg::STATE_ADDR;
			aesRoundPkg::STATE_ADDR:
				nextState = STATE_READ;
			STATE_READ:
				nextState = STATE_CAPTURE;
			STATE_CAPTURE:
				nextState = MIX;
			MIX:
			begin
				if (bus.mixDone)
					nextState = WRITE_SETUP;
			end
			WRITE_SETUP:
				nextState = WRITE_STROBE;
			WRITE_STROBE:
				nextState = FINISH;
			FINISH:
				nextState = IDLE;
			default:
				nextState = IDLE;
		endcase
	end

	// **************************************************
	// Key and state capture
	// **************************************************

	// The SRAM holds the word from the cycle after the strobe
	always_ff @(posedge clk)
	begin
		if (state == KEY_CAPTURE)
			keyWord <= sramReadData;
		if (state == STATE_CAPTURE)
			stateWord <= sramReadData;
	end

	assign bus.roundKey = keyWord;
	assign bus.oldState = stateWord;

	// The state word lands at the end of this cycle, so the mixer sees it
	// from its first lane on
	assign bus.mixStart = (state == STATE_CAPTURE);

	// **************************************************
	// SRAM side and finished pulse
	// **************************************************

	always_comb
	begin
		sramRead = 1'b0;
		sramWrite = 1'b0;
		sramAddr = '0;
		sramWriteData = '0;
		roundFinished = 1'b0;
		case (state)
			aesRoundPkg::KEY_ADDR:
				sramAddr = KEY_ADDR;
			KEY_READ:
			begin
				sramAddr = KEY_ADDR;
				sramRead = 1'b1;
			end
			aesRoundPkg::STATE_ADDR:
				sramAddr = STATE_ADDR;
			STATE_READ:
			begin
				sramAddr = STATE_ADDR;
				sramRead = 1'b1;
			end
			WRITE_SETUP:
			begin
				sramAddr = STATE_ADDR;
				sramWriteData = bus.newState;  // Result goes back over the old state
			end
			WRITE_STROBE:
			begin
				sramAddr = STATE_ADDR;
				sramWriteData = bus.newState;
				sramWrite = 1'b1;
			end
			FINISH:
				roundFinished = 1'b1;
			default:
				sramAddr = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- roundBus.sv
/*
 * Round bus
 * Carries the fetched key and state from the sequencer to the byte mixer
 * and the mixed state back, along with the start and done pulses
 */
`timescale 1ns/1ns
`default_nettype none

interface roundBus;
	import aesRoundPkg::*;

	blockT roundKey;
	blockT oldState;
	blockT newState;  // Valid from the cycle after mixDone
	logic mixStart;   // One cycle, once key and state are fetched
	logic mixDone;    // High while the last lane is written

	modport seq (
		output roundKey,
		output oldState,
		output mixStart,
		input newState,
		input mixDone
	);

	modport mix (
		input roundKey,
		input oldState,
		input mixStart,
		output newState,
		output mixDone
	);

endinterface

`default_nettype wire

//--- aesRoundPkg.sv
/*
 * AES round package
 * Block, byte, address and lane types for the AddRoundKey datapath,
 * together with the lane count and the sequencer state encoding
 */
`default_nettype none

package aesRoundPkg;

	// **************************************************
	// Block geometry
	// **************************************************

	localparam int unsigned BLOCK_BYTES = 16;  // Byte lanes in one AES block

	// One AES block, used for both the round key and the cipher state
	typedef logic [BLOCK_BYTES*8-1:0] blockT;

	typedef logic [7:0] byteT;  // A single byte lane

	typedef logic [15:0] addrT;  // SRAM word address

	// Index of a byte lane, lane 0 being the lowest byte of the block
	typedef logic [$clog2(BLOCK_BYTES)-1:0] laneT;

	// **************************************************
	// Sequencer states
	// **************************************************

	// Each fetch takes three cycles: present the address, strobe, then capture
	typedef enum logic [3:0] {
		IDLE,
		KEY_ADDR,
		KEY_READ,
		KEY_CAPTURE,
		STATE_ADDR,
		STATE_READ,
		STATE_CAPTURE,
		MIX,           // Waits here until the mixer reports the last lane
		WRITE_SETUP,
		WRITE_STROBE,
		FINISH
	} seqStateT;

endpackage

`default_nettype wire
